// File: logic/pcie_hdr_pkg.sv
//##########################################################################
// PCIe header definitions
// Field widths, format codes and the fixed bit layout of the 128-bit
// header carried on the transmit stream and in generated completions
//##########################################################################
package pcie_hdr_pkg;

   localparam int HDR_W  = 128;
   localparam int DATA_W = 256;
   localparam int KEEP_W = DATA_W / 8;

   localparam int FMT_W    = 8;
   localparam int LEN_W    = 10;
   localparam int TAG_W    = 10;
   localparam int REQ_ID_W = 16;
   localparam int STAT_W   = 3;
   localparam int BCNT_W   = 12;
   localparam int LADDR_W  = 7;

   typedef logic [TAG_W-1:0]    t_tag;
   typedef logic [REQ_ID_W-1:0] t_req_id;
   typedef logic [LEN_W-1:0]    t_dw_len;
   typedef logic [BCNT_W-1:0]   t_byte_cnt;
   typedef logic [LADDR_W-1:0]  t_low_addr;
   typedef logic [FMT_W-1:0]    t_fmt_type;
   typedef logic [HDR_W-1:0]    t_hdr;
   typedef logic [DATA_W-1:0]   t_tdata;
   typedef logic [KEEP_W-1:0]   t_tkeep;

   localparam t_fmt_type FMT_CPLD = 8'h4a;
   localparam t_fmt_type FMT_MRD  = 8'h20;

   // Lowest bit of each header field
   localparam int FMT_LSB    = 0;
   localparam int LEN_LSB    = 8;
   localparam int TAG_LSB    = 18;
   localparam int REQ_ID_LSB = 28;
   localparam int STAT_LSB   = 44;
   localparam int BCNT_LSB   = 47;
   localparam int LADDR_LSB  = 59;

   // A read request carries its address in the upper 64 bits instead
   localparam int ADDR_LSB   = 64;

   // Completion keep: 16 header bytes plus one or two payload dwords
   localparam t_tkeep KEEP_1DW = 32'h000f_ffff;
   localparam t_tkeep KEEP_2DW = 32'h00ff_ffff;

endpackage

// File: logic/tx_err_pkg.sv
//##########################################################################
// Transmit error filter definitions
// Controller states, delay and queue sizes, the read timeout and the
// layout of one pending MMIO read record
//##########################################################################
package tx_err_pkg;

   typedef enum logic [1:0] {
      F_IDLE,
      F_SEND_RSP,
      F_WAIT_QUEUE,
      F_IDLE_BLOCKING
   } t_filt_state;

   localparam int PIPE_DEPTH = 4;

   localparam int PEND_DEPTH = 8;
   localparam int PEND_PTR_W = $clog2(PEND_DEPTH);

   localparam int MMIO_TIMEOUT_CYCLES = 64;
   localparam int AGE_W = $clog2(MMIO_TIMEOUT_CYCLES + 1);

   localparam int PEND_W = 40;
   typedef logic [PEND_W-1:0] t_pend_info;

   // Record layout, the bits above the tag are spare and stay zero
   localparam int PI_IS32_BIT   = 0;
   localparam int PI_LADDR_LSB  = 1;
   localparam int PI_REQ_ID_LSB = 8;
   localparam int PI_TAG_LSB    = 24;

endpackage

// File: logic/mmio_pending_queue.sv
//##########################################################################
// MMIO pending read queue
// Keeps outstanding host reads in arrival order and times the oldest one.
// A read that stays at the head too long raises a single timeout pulse
//##########################################################################
`timescale 1ns/1ps

module mmio_pending_queue (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   i_mmio_req_valid,
   input  pcie_hdr_pkg::t_hdr     i_mmio_req_hdr,
   input  logic                   i_afu_cpl_seen,
   input  logic                   i_cpl_sent,
   input  logic                   i_blocking,
   output tx_err_pkg::t_pend_info o_head_info,
   output logic                   o_next_pending_rdy,
   output logic                   o_flush_done,
   output logic                   o_mmio_timeout,
   output logic                   o_pend_overflow
);
   import pcie_hdr_pkg::*;
   import tx_err_pkg::*;

   t_pend_info            mem [PEND_DEPTH];
   logic [PEND_PTR_W-1:0] wr_ptr;
   logic [PEND_PTR_W-1:0] rd_ptr;
   logic [PEND_PTR_W:0]   count;
   logic [AGE_W-1:0]      age;
   logic                  empty;
   logic                  full;
   logic                  push;
   logic                  pop;
   t_pend_info            new_info;

   assign empty = (count == '0);
   assign full  = (count == (PEND_PTR_W + 1)'(PEND_DEPTH));
   assign push  = i_mmio_req_valid & ~full;

   // AFU completions retire reads only while traffic is flowing
   assign pop = ~empty & (i_cpl_sent | (i_afu_cpl_seen & ~i_blocking));

   always_comb begin
      new_info = '0;
      new_info[PI_TAG_LSB +: TAG_W]       = i_mmio_req_hdr[TAG_LSB +: TAG_W];
      new_info[PI_REQ_ID_LSB +: REQ_ID_W] = i_mmio_req_hdr[REQ_ID_LSB +: REQ_ID_W];
      new_info[PI_LADDR_LSB +: LADDR_W]   = i_mmio_req_hdr[ADDR_LSB +: LADDR_W];
      new_info[PI_IS32_BIT] = (i_mmio_req_hdr[LEN_LSB +: LEN_W] == t_dw_len'(1));
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= new_info;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr          <= '0;
         rd_ptr          <= '0;
         count           <= '0;
         o_pend_overflow <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         // A dropped request is remembered until reset
         if (i_mmio_req_valid & full) begin
            o_pend_overflow <= 1'b1;
         end
      end
   end

   // Age of the head entry, saturating so the timeout fires once per entry
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         age            <= '0;
         o_mmio_timeout <= 1'b0;
      end else begin
         o_mmio_timeout <= 1'b0;
         if (empty | pop) begin
            age <= '0;
         end else if (age != AGE_W'(MMIO_TIMEOUT_CYCLES)) begin
            age <= age + 1'b1;
            if (age == AGE_W'(MMIO_TIMEOUT_CYCLES - 1)) begin
               o_mmio_timeout <= 1'b1;
            end
         end
      end
   end

   assign o_head_info        = mem[rd_ptr];
   assign o_next_pending_rdy = ~empty;
   assign o_flush_done       = empty;

endmodule

// File: logic/tx_delay_pipe.sv
//##########################################################################
// Transmit stream delay line
// Four stages that advance together while the link is ready. Each stage
// keeps the last packet header it saw, and stage 1 flags AFU completions
//##########################################################################
`timescale 1ns/1ps

module tx_delay_pipe (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 i_tx_valid,
   input  pcie_hdr_pkg::t_tdata i_tx_data,
   input  pcie_hdr_pkg::t_tkeep i_tx_keep,
   input  logic                 i_tx_last,
   input  logic                 i_tx_sop,
   input  logic                 i_tx_ready,
   output logic                 o_tx_ready,
   output logic                 o_tx_valid_r4,
   output pcie_hdr_pkg::t_tdata o_tx_data_r4,
   output pcie_hdr_pkg::t_tkeep o_tx_keep_r4,
   output logic                 o_tx_last_r4,
   output logic                 o_tx_sop_r4,
   output pcie_hdr_pkg::t_hdr   o_tx_hdr_r1,
   output pcie_hdr_pkg::t_hdr   o_tx_hdr_r2,
   output pcie_hdr_pkg::t_hdr   o_tx_hdr_r3,
   output pcie_hdr_pkg::t_hdr   o_tx_hdr_r4,
   output logic                 o_afu_cpl_seen
);
   import pcie_hdr_pkg::*;
   import tx_err_pkg::*;

   logic   valid_r [1:PIPE_DEPTH];
   t_tdata data_r  [1:PIPE_DEPTH];
   t_tkeep keep_r  [1:PIPE_DEPTH];
   logic   last_r  [1:PIPE_DEPTH];
   logic   sop_r   [1:PIPE_DEPTH];
   t_hdr   hdr_r   [1:PIPE_DEPTH];
   logic   cpl_in;

   // Ready goes straight back upstream, it is not delayed with the data
   assign o_tx_ready = i_tx_ready;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int k = 1; k <= PIPE_DEPTH; k++) begin
            valid_r[k] <= 1'b0;
         end
      end else if (i_tx_ready) begin
         valid_r[1] <= i_tx_valid;
         for (int k = 2; k <= PIPE_DEPTH; k++) begin
            valid_r[k] <= valid_r[k-1];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_tx_ready) begin
         data_r[1] <= i_tx_data;
         keep_r[1] <= i_tx_keep;
         last_r[1] <= i_tx_last;
         sop_r[1]  <= i_tx_sop;
         for (int k = 2; k <= PIPE_DEPTH; k++) begin
            data_r[k] <= data_r[k-1];
            keep_r[k] <= keep_r[k-1];
            last_r[k] <= last_r[k-1];
            sop_r[k]  <= sop_r[k-1];
         end
      end
   end

   // Stage k takes a header when a valid sop beat moves into it
   always_ff @(posedge clk) begin
      if (i_tx_ready & i_tx_valid & i_tx_sop) begin
         hdr_r[1] <= i_tx_data[HDR_W-1:0];
      end
      for (int k = 2; k <= PIPE_DEPTH; k++) begin
         if (i_tx_ready & valid_r[k-1] & sop_r[k-1]) begin
            hdr_r[k] <= data_r[k-1][HDR_W-1:0];
         end
      end
   end

   assign cpl_in = i_tx_ready & i_tx_valid & i_tx_sop &
                   (i_tx_data[FMT_LSB +: FMT_W] == FMT_CPLD);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         o_afu_cpl_seen <= 1'b0;
      end else begin
         o_afu_cpl_seen <= cpl_in;
      end
   end

   assign o_tx_valid_r4 = valid_r[PIPE_DEPTH];
   assign o_tx_data_r4  = data_r[PIPE_DEPTH];
   assign o_tx_keep_r4  = keep_r[PIPE_DEPTH];
   assign o_tx_last_r4  = last_r[PIPE_DEPTH];
   assign o_tx_sop_r4   = sop_r[PIPE_DEPTH];
   assign o_tx_hdr_r1   = hdr_r[1];
   assign o_tx_hdr_r2   = hdr_r[2];
   assign o_tx_hdr_r3   = hdr_r[3];
   assign o_tx_hdr_r4   = hdr_r[4];

endmodule

// File: logic/cpl_builder.sv
//##########################################################################
// Fake completion builder
// Turns the oldest pending read into a one-beat completion with an
// all-ones payload and holds it until the link accepts it
//##########################################################################
`timescale 1ns/1ps

module cpl_builder (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   i_send_rsp,
   input  tx_err_pkg::t_pend_info i_head_info,
   input  logic                   i_cpl_ready,
   output logic                   o_cpl_valid,
   output pcie_hdr_pkg::t_tdata   o_cpl_data,
   output pcie_hdr_pkg::t_tkeep   o_cpl_keep,
   output logic                   o_cpl_sop,
   output logic                   o_cpl_last,
   output logic                   o_cpl_sent,
   output logic                   o_mmio_rd_rsp_ack
);
   import pcie_hdr_pkg::*;
   import tx_err_pkg::*;

   t_pend_info info_q;
   t_hdr       cpl_hdr;
   logic       is_32b;

   // The record is captured as the response starts and held while stalled
   always_ff @(posedge clk) begin
      if (i_send_rsp & ~o_cpl_valid) begin
         info_q <= i_head_info;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         o_cpl_valid       <= 1'b0;
         o_mmio_rd_rsp_ack <= 1'b0;
      end else begin
         o_mmio_rd_rsp_ack <= o_cpl_sent;
         if (o_cpl_sent) begin
            o_cpl_valid <= 1'b0;
         end else if (i_send_rsp) begin
            o_cpl_valid <= 1'b1;
         end
      end
   end

   assign is_32b = info_q[PI_IS32_BIT];

   always_comb begin
      cpl_hdr = '0;
      cpl_hdr[FMT_LSB +: FMT_W]       = FMT_CPLD;
      cpl_hdr[LEN_LSB +: LEN_W]       = is_32b ? t_dw_len'(1) : t_dw_len'(2);
      cpl_hdr[TAG_LSB +: TAG_W]       = info_q[PI_TAG_LSB +: TAG_W];
      cpl_hdr[REQ_ID_LSB +: REQ_ID_W] = info_q[PI_REQ_ID_LSB +: REQ_ID_W];
      cpl_hdr[STAT_LSB +: STAT_W]     = '0;
      cpl_hdr[BCNT_LSB +: BCNT_W]     = is_32b ? t_byte_cnt'(4) : t_byte_cnt'(8);
      cpl_hdr[LADDR_LSB +: LADDR_W]   = info_q[PI_LADDR_LSB +: LADDR_W];
   end

   assign o_cpl_data = {{(DATA_W - HDR_W){1'b1}}, cpl_hdr};
   assign o_cpl_keep = is_32b ? KEEP_1DW : KEEP_2DW;
   assign o_cpl_sop  = o_cpl_valid;
   assign o_cpl_last = o_cpl_valid;
   assign o_cpl_sent = o_cpl_valid & i_cpl_ready;

endmodule

// File: logic/tx_error_ctrl.sv
//##########################################################################
// Transmit error controller
// Decides when pending reads are flushed with fake completions and
// holds the traffic block until errors are cleared or a soft reset ends
//##########################################################################
`timescale 1ns/1ps

module tx_error_ctrl (
   input  logic clk,
   input  logic rst_n,
   input  logic i_block_traffic,
   input  logic i_clear_errors,
   input  logic i_afu_softreset,
   input  logic i_mmio_timeout,
   input  logic i_next_pending_rdy,
   input  logic i_flush_done,
   input  logic i_cpl_sent,
   output logic o_send_rsp,
   output logic o_blocking_traffic,
   output logic o_blocking_traffic_fast
);
   import tx_err_pkg::*;

   t_filt_state state;
   t_filt_state state_next;
   logic        in_idle;
   logic        softreset_r1;
   logic        softreset_r2;
   logic        softreset_fall;
   logic        clear_seen;
   logic        softreset_seen;

   assign in_idle = (state == F_IDLE);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= F_IDLE;
      end else begin
         state <= state_next;
      end
   end

   always_comb begin
      state_next = state;
      case (state)
         F_IDLE: begin
            if (i_mmio_timeout) begin
               state_next = F_SEND_RSP;
            end else if (i_block_traffic) begin
               state_next = F_WAIT_QUEUE;
            end
         end
         // One fake completion is on the link, wait until it is taken
         F_SEND_RSP: begin
            if (i_cpl_sent) begin
               state_next = F_WAIT_QUEUE;
            end
         end
         F_WAIT_QUEUE: begin
            if (i_next_pending_rdy) begin
               state_next = F_SEND_RSP;
            end else if (i_flush_done) begin
               state_next = F_IDLE_BLOCKING;
            end
         end
         // Queue is drained but traffic stays blocked; new reads still get answered
         F_IDLE_BLOCKING: begin
            if (clear_seen | softreset_seen) begin
               state_next = F_IDLE;
            end else if (i_next_pending_rdy) begin
               state_next = F_SEND_RSP;
            end
         end
         default: state_next = F_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         softreset_r1       <= 1'b0;
         softreset_r2       <= 1'b0;
         softreset_fall     <= 1'b0;
         clear_seen         <= 1'b0;
         softreset_seen     <= 1'b0;
         o_blocking_traffic <= 1'b0;
      end else begin
         // Soft reset comes from the accelerator side, so sync it first
         softreset_r1   <= i_afu_softreset;
         softreset_r2   <= softreset_r1;
         softreset_fall <= softreset_r2 & ~softreset_r1;
         // Sticky flags are dropped once the controller is back in idle
         clear_seen         <= i_clear_errors | (clear_seen & ~in_idle);
         softreset_seen     <= softreset_fall | (softreset_seen & ~in_idle);
         o_blocking_traffic <= i_block_traffic | i_mmio_timeout |
                               (o_blocking_traffic & ~in_idle);
      end
   end

   assign o_send_rsp              = (state == F_SEND_RSP);
   assign o_blocking_traffic_fast = i_block_traffic | o_blocking_traffic;

endmodule

// File: logic/tx_filter_top.sv
//##########################################################################
// Transmit error filter
// Delays the accelerator transmit stream, tracks host MMIO reads and
// answers them with fake completions once traffic has to be blocked
//##########################################################################
`timescale 1ns/1ps

module tx_filter_top (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 i_tx_valid,
   input  pcie_hdr_pkg::t_tdata i_tx_data,
   input  pcie_hdr_pkg::t_tkeep i_tx_keep,
   input  logic                 i_tx_last,
   input  logic                 i_tx_sop,
   input  logic                 i_tx_ready,
   output logic                 o_tx_ready,
   output logic                 o_tx_valid_r4,
   output pcie_hdr_pkg::t_tdata o_tx_data_r4,
   output pcie_hdr_pkg::t_tkeep o_tx_keep_r4,
   output logic                 o_tx_last_r4,
   output logic                 o_tx_sop_r4,
   output pcie_hdr_pkg::t_hdr   o_tx_hdr_r1,
   output pcie_hdr_pkg::t_hdr   o_tx_hdr_r2,
   output pcie_hdr_pkg::t_hdr   o_tx_hdr_r3,
   output pcie_hdr_pkg::t_hdr   o_tx_hdr_r4,
   input  logic                 i_mmio_req_valid,
   input  pcie_hdr_pkg::t_hdr   i_mmio_req_hdr,
   output logic                 o_pend_overflow,
   output logic                 o_mmio_timeout,
   input  logic                 i_block_traffic,
   input  logic                 i_clear_errors,
   input  logic                 i_afu_softreset,
   output logic                 o_blocking_traffic,
   output logic                 o_blocking_traffic_fast,
   output logic                 o_cpl_valid,
   output pcie_hdr_pkg::t_tdata o_cpl_data,
   output pcie_hdr_pkg::t_tkeep o_cpl_keep,
   output logic                 o_cpl_sop,
   output logic                 o_cpl_last,
   input  logic                 i_cpl_ready,
   output logic                 o_mmio_rd_rsp_ack
);
   import tx_err_pkg::*;

   t_pend_info head_info;
   logic       next_pending_rdy;
   logic       flush_done;
   logic       afu_cpl_seen;
   logic       cpl_sent;
   logic       send_rsp;

   tx_delay_pipe u_pipe (
      .clk, .rst_n,
      .i_tx_valid, .i_tx_data, .i_tx_keep, .i_tx_last, .i_tx_sop, .i_tx_ready,
      .o_tx_ready, .o_tx_valid_r4, .o_tx_data_r4, .o_tx_keep_r4,
      .o_tx_last_r4, .o_tx_sop_r4,
      .o_tx_hdr_r1, .o_tx_hdr_r2, .o_tx_hdr_r3, .o_tx_hdr_r4,
      .o_afu_cpl_seen (afu_cpl_seen)
   );

   // The unregistered block flag keeps a completion from retiring a read
   // in the same cycle that an error arrives
   mmio_pending_queue u_queue (
      .clk, .rst_n,
      .i_mmio_req_valid, .i_mmio_req_hdr,
      .i_afu_cpl_seen     (afu_cpl_seen),
      .i_cpl_sent         (cpl_sent),
      .i_blocking         (o_blocking_traffic_fast),
      .o_head_info        (head_info),
      .o_next_pending_rdy (next_pending_rdy),
      .o_flush_done       (flush_done),
      .o_mmio_timeout,
      .o_pend_overflow
   );

   cpl_builder u_cpl (
      .clk, .rst_n,
      .i_send_rsp  (send_rsp),
      .i_head_info (head_info),
      .i_cpl_ready,
      .o_cpl_valid, .o_cpl_data, .o_cpl_keep, .o_cpl_sop, .o_cpl_last,
      .o_cpl_sent  (cpl_sent),
      .o_mmio_rd_rsp_ack
   );

   tx_error_ctrl u_ctrl (
      .clk, .rst_n,
      .i_block_traffic, .i_clear_errors, .i_afu_softreset,
      .i_mmio_timeout     (o_mmio_timeout),
      .i_next_pending_rdy (next_pending_rdy),
      .i_flush_done       (flush_done),
      .i_cpl_sent         (cpl_sent),
      .o_send_rsp         (send_rsp),
      .o_blocking_traffic,
      .o_blocking_traffic_fast
   );

endmodule

// File: tests/tb_clk_gen.sv
//############################################################################
// Testbench clock and reset generator
// Free running clock and an active low reset held for a few cycles
//############################################################################
`timescale 1ns/1ps

module tb_clk_gen #(
   parameter int PERIOD_NS  = 100,
   parameter int RST_CYCLES = 3
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // Reset is released on a falling edge, away from the sampling edge
   initial begin
      rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule

// File: tests/tx_filter_tb.sv
//############################################################################
// Transmit error filter testbench
// Drives the delay line, host reads, AFU completions and error inputs,
// and checks every cycle against a reference model of the filter
//############################################################################
`timescale 1ns/1ps

module tx_filter_tb;
   localparam int N_SECTIONS  = 5;
   localparam int WATCHDOG_NS = N_SECTIONS * 20000 + 20000;

   logic clk, rst_n;
   logic i_tx_valid, i_tx_last, i_tx_sop, i_tx_ready;
   logic [255:0] i_tx_data;
   logic [31:0] i_tx_keep;
   logic i_mmio_req_valid;
   logic [127:0] i_mmio_req_hdr;
   logic i_block_traffic, i_clear_errors, i_afu_softreset, i_cpl_ready;
   logic o_tx_ready, o_tx_valid_r4, o_tx_last_r4, o_tx_sop_r4;
   logic [255:0] o_tx_data_r4, o_cpl_data;
   logic [31:0] o_tx_keep_r4, o_cpl_keep;
   logic [127:0] dut_hdr [1:4];
   logic o_pend_overflow, o_mmio_timeout, o_blocking_traffic, o_blocking_traffic_fast;
   logic o_cpl_valid, o_cpl_sop, o_cpl_last, o_mmio_rd_rsp_ack;

   // Reference model state
   logic [31:0] lfsr = 32'h0d8ed22b;
   logic [255:0] md [1:4];
   logic [31:0] mk [1:4];
   logic mv [1:4];
   logic ml [1:4];
   logic ms [1:4];
   logic [127:0] mh [1:4];
   logic hv [1:4];
   logic [127:0] pend_q [$];
   int age, sent_cnt;
   logic exp_to, cpl_seen_d, prev_sent, prev_stall, m_sent, m_pop, m_full;
   logic exp_blk, exp_ovf, sr_prev, m_release;
   logic [1:0] clr_h;
   logic [3:0] srf_h;
   logic [255:0] prev_data;
   logic tx_rand, cpl_rand, cpl_level, expect_quiet;

   tb_clk_gen u_clk (.clk(clk), .rst_n(rst_n));

   tx_filter_top dut (
      .clk, .rst_n, .i_tx_valid, .i_tx_data, .i_tx_keep, .i_tx_last, .i_tx_sop,
      .i_tx_ready, .o_tx_ready, .o_tx_valid_r4, .o_tx_data_r4, .o_tx_keep_r4,
      .o_tx_last_r4, .o_tx_sop_r4,
      .o_tx_hdr_r1(dut_hdr[1]), .o_tx_hdr_r2(dut_hdr[2]),
      .o_tx_hdr_r3(dut_hdr[3]), .o_tx_hdr_r4(dut_hdr[4]),
      .i_mmio_req_valid, .i_mmio_req_hdr, .o_pend_overflow, .o_mmio_timeout,
      .i_block_traffic, .i_clear_errors, .i_afu_softreset, .o_blocking_traffic,
      .o_blocking_traffic_fast, .o_cpl_valid, .o_cpl_data, .o_cpl_keep,
      .o_cpl_sop, .o_cpl_last, .i_cpl_ready, .o_mmio_rd_rsp_ack
   );

   task automatic report_mismatch(input string msg);
      $display("FAILED at %0t: %s", $time, msg);
      $display("Done: errors found");
      $fatal(1, "check failed");
   endtask

   task automatic report_hang(input string msg);
      $display("%s", msg);
      $display("Done: errors found");
      $fatal(1, "run stopped");
   endtask

   // Galois LFSR stepped once per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic b;
      r = '0;
      for (int i = 0; i < n; i++) begin
         b = lfsr[0];
         lfsr = lfsr >> 1;
         if (b) lfsr = lfsr ^ 32'ha300_0000;
         r = {r[30:0], b};
      end
      return r;
   endfunction

   function automatic logic [255:0] rand_data();
      logic [255:0] d;
      for (int i = 0; i < 8; i++) d[i*32 +: 32] = rand_bits(32);
      return d;
   endfunction

   // Completion expected for a read request header
   function automatic logic [255:0] exp_cpl_data(input logic [127:0] req);
      logic [255:0] d;
      logic is32;
      is32 = (req[17:8] == 10'd1);
      d = '1;
      d[127:0] = '0;
      d[7:0] = 8'h4a;
      d[17:8] = is32 ? 10'd1 : 10'd2;
      d[27:18] = req[27:18];
      d[43:28] = req[43:28];
      d[46:44] = 3'b000;
      d[58:47] = is32 ? 12'd4 : 12'd8;
      d[65:59] = req[70:64];
      return d;
   endfunction

   function automatic logic [31:0] exp_cpl_keep(input logic [127:0] req);
      return (req[17:8] == 10'd1) ? 32'h000f_ffff : 32'h00ff_ffff;
   endfunction

   always @(negedge clk) begin
      i_tx_ready <= tx_rand ? (rand_bits(1) != 0) : 1'b1;
      i_cpl_ready <= cpl_rand ? (rand_bits(1) != 0) : cpl_level;
   end

   // Compares pre-edge outputs with the model, then advances the model
   always @(posedge clk) begin
      if (!rst_n) begin
         for (int k = 1; k <= 4; k++) begin
            mv[k] = 1'b0;
            hv[k] = 1'b0;
         end
         pend_q.delete();
         age = 0;
         exp_to = 1'b0;
         cpl_seen_d = 1'b0;
         prev_sent = 1'b0;
         prev_stall = 1'b0;
         exp_blk = 1'b0;
         exp_ovf = 1'b0;
         sr_prev = 1'b0;
         clr_h = '0;
         srf_h = '0;
      end else begin
         assert (o_tx_ready == i_tx_ready) else report_mismatch("o_tx_ready differs");
         assert (o_tx_valid_r4 == mv[4]) else report_mismatch("o_tx_valid_r4 wrong");
         if (mv[4]) begin
            assert (o_tx_data_r4 == md[4] && o_tx_keep_r4 == mk[4] &&
                    o_tx_last_r4 == ml[4] && o_tx_sop_r4 == ms[4])
               else report_mismatch("r4 beat does not match the input beat");
         end
         for (int k = 1; k <= 4; k++) begin
            if (hv[k]) assert (dut_hdr[k] == mh[k]) else report_mismatch("stage header wrong");
         end
         assert (o_blocking_traffic == exp_blk) else report_mismatch("o_blocking_traffic wrong");
         assert (o_blocking_traffic_fast == (i_block_traffic | exp_blk))
            else report_mismatch("o_blocking_traffic_fast wrong");
         assert (o_pend_overflow == exp_ovf) else report_mismatch("o_pend_overflow wrong");
         if (expect_quiet) begin
            assert (!o_cpl_valid && !o_blocking_traffic)
               else report_mismatch("fake completion or blocking while quiet");
         end
         assert (o_mmio_timeout == exp_to) else report_mismatch("o_mmio_timeout wrong");
         assert (o_mmio_rd_rsp_ack == prev_sent) else report_mismatch("ack wrong");
         assert (o_cpl_sop == o_cpl_valid && o_cpl_last == o_cpl_valid)
            else report_mismatch("completion sop or last wrong");
         if (prev_stall) begin
            assert (o_cpl_valid && o_cpl_data == prev_data)
               else report_mismatch("stalled completion changed");
         end
         if (o_cpl_valid) begin
            assert (pend_q.size() != 0) else report_mismatch("completion with no read pending");
            if (pend_q.size() != 0) begin
               assert (o_cpl_data == exp_cpl_data(pend_q[0]) &&
                       o_cpl_keep == exp_cpl_keep(pend_q[0]))
                  else report_mismatch("completion content wrong");
            end
         end

         m_sent = o_cpl_valid & i_cpl_ready;
         m_pop = m_sent |
                 (cpl_seen_d & !(i_block_traffic | exp_blk) & (pend_q.size() != 0));
         m_full = (pend_q.size() >= 8);
         // Blocking drops two edges after a sampled clear and four edges
         // after the sampled end of a soft reset
         m_release = clr_h[1] | srf_h[3];
         exp_blk = i_block_traffic | exp_to | (exp_blk & !m_release);
         clr_h = {clr_h[0], i_clear_errors};
         srf_h = {srf_h[2:0], sr_prev & !i_afu_softreset};
         sr_prev = i_afu_softreset;
         if (i_mmio_req_valid && m_full) exp_ovf = 1'b1;
         exp_to = (pend_q.size() != 0) && !m_pop && (age == 63);
         if (pend_q.size() == 0 || m_pop) age = 0;
         else if (age != 64) age++;
         if (m_pop && pend_q.size() != 0) void'(pend_q.pop_front());
         if (i_mmio_req_valid && !m_full) pend_q.push_back(i_mmio_req_hdr);
         if (m_sent) sent_cnt++;
         cpl_seen_d = i_tx_ready & i_tx_valid & i_tx_sop & (i_tx_data[7:0] == 8'h4a);
         if (i_tx_ready) begin
            for (int k = 4; k >= 2; k--) begin
               if (mv[k-1] && ms[k-1]) begin
                  mh[k] = md[k-1][127:0];
                  hv[k] = 1'b1;
               end
               mv[k] = mv[k-1];
               md[k] = md[k-1];
               mk[k] = mk[k-1];
               ml[k] = ml[k-1];
               ms[k] = ms[k-1];
            end
            if (i_tx_valid && i_tx_sop) begin
               mh[1] = i_tx_data[127:0];
               hv[1] = 1'b1;
            end
            mv[1] = i_tx_valid;
            md[1] = i_tx_data;
            mk[1] = i_tx_keep;
            ml[1] = i_tx_last;
            ms[1] = i_tx_sop;
         end
         prev_sent = m_sent;
         prev_stall = o_cpl_valid & !i_cpl_ready;
         prev_data = o_cpl_data;
      end
   end

   task automatic send_beat(input logic [255:0] d, input logic sop, input logic last);
      @(negedge clk);
      i_tx_valid = 1'b1;
      i_tx_data = d;
      i_tx_keep = rand_bits(32);
      i_tx_sop = sop;
      i_tx_last = last;
      do @(posedge clk); while (!i_tx_ready);
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(negedge clk);
         i_tx_valid = 1'b0;
      end
   endtask

   task automatic send_read(input logic is32);
      logic [255:0] r;
      r = rand_data();
      r[7:0] = 8'h20;
      r[17:8] = is32 ? 10'd1 : 10'd2;
      @(negedge clk);
      i_tx_valid = 1'b0;
      i_mmio_req_hdr = r[127:0];
      i_mmio_req_valid = 1'b1;
      @(negedge clk);
      i_mmio_req_valid = 1'b0;
   endtask

   task automatic send_afu_cpl();
      logic [255:0] d;
      d = rand_data();
      d[7:0] = 8'h4a;
      send_beat(d, 1'b1, 1'b1);
      idle(1);
   endtask

   task automatic wait_drained(input int target);
      int n;
      n = 0;
      while (sent_cnt < target || pend_q.size() != 0 || o_cpl_valid) begin
         @(negedge clk);
         n++;
         if (n > 400) report_hang("Timed out waiting for the pending reads to be flushed");
      end
   endtask

   task automatic release_block(input logic use_softreset);
      int n;
      @(negedge clk);
      if (use_softreset) begin
         i_afu_softreset = 1'b1;
         repeat (4) @(negedge clk);
         i_afu_softreset = 1'b0;
      end else begin
         i_clear_errors = 1'b1;
         @(negedge clk);
         i_clear_errors = 1'b0;
      end
      n = 0;
      while (o_blocking_traffic) begin
         @(negedge clk);
         n++;
         if (n > 30) report_hang("Blocking flag was not released");
      end
      idle(3);
   endtask

   task automatic pulse_block();
      @(negedge clk);
      i_block_traffic = 1'b1;
      @(negedge clk);
      i_block_traffic = 1'b0;
   endtask

   initial begin
      #(WATCHDOG_NS);
      report_hang("Watchdog expired before the tests finished");
   end

   initial begin
      int base;
      i_tx_valid = 1'b0;
      i_tx_data = '0;
      i_tx_keep = '0;
      i_tx_last = 1'b0;
      i_tx_sop = 1'b0;
      i_tx_ready = 1'b1;
      i_mmio_req_valid = 1'b0;
      i_mmio_req_hdr = '0;
      i_block_traffic = 1'b0;
      i_clear_errors = 1'b0;
      i_afu_softreset = 1'b0;
      i_cpl_ready = 1'b1;
      tx_rand = 1'b0;
      cpl_rand = 1'b0;
      cpl_level = 1'b1;
      expect_quiet = 1'b1;
      sent_cnt = 0;
      @(posedge rst_n);

      // Random beats under random back-pressure
      tx_rand = 1;
      for (int i = 0; i < 60; i++) begin
         send_beat(rand_data(), rand_bits(1) != 0, rand_bits(1) != 0);
         if (rand_bits(2) == 0) idle(1);
      end
      idle(12);
      tx_rand = 0;
      idle(2);

      // Reads answered in time by the AFU
      for (int i = 0; i < 3; i++) begin
         send_read(rand_bits(1) != 0);
         idle(int'(rand_bits(4)));
         send_afu_cpl();
      end
      idle(80);

      // A single unanswered read times out
      expect_quiet = 0;
      base = sent_cnt;
      send_read(rand_bits(1) != 0);
      wait_drained(base + 1);
      idle(2);
      assert (o_blocking_traffic) else report_mismatch("no blocking after timeout");
      release_block(1'b0);

      // Several reads flushed by an error under random completion ready
      cpl_rand = 1;
      base = sent_cnt;
      for (int i = 0; i < 4; i++) send_read(rand_bits(1) != 0);
      pulse_block();
      wait_drained(base + 4);
      idle(2);
      assert (o_blocking_traffic) else report_mismatch("no blocking after flush");
      cpl_rand = 0;
      release_block(1'b0);

      // AFU completions are ignored while blocked
      cpl_level = 0;
      pulse_block();
      idle(5);
      base = sent_cnt;
      send_read(1'b1);
      send_read(1'b0);
      idle(10);
      send_afu_cpl();
      idle(5);
      cpl_level = 1;
      wait_drained(base + 2);
      assert (sent_cnt == base + 2) else report_mismatch("wrong number of fake completions");
      assert (o_blocking_traffic) else report_mismatch("blocking dropped early");
      release_block(1'b1);
      expect_quiet = 1;
      send_read(1'b0);
      idle(5);
      send_afu_cpl();
      idle(80);

      $display("Done: no errors");
      $finish;
   end

endmodule

// File: build.f
logic/pcie_hdr_pkg.sv
logic/tx_err_pkg.sv
logic/mmio_pending_queue.sv
logic/tx_delay_pipe.sv
logic/cpl_builder.sv
logic/tx_error_ctrl.sv
logic/tx_filter_top.sv
tests/tb_clk_gen.sv
tests/tx_filter_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f build.f --top-module tx_filter_tb -o tx_filter_sim
./obj_dir/tx_filter_sim
